//--- common/kalman_pkg.sv
package kalman_pkg;

	// datapath word width, shared by state, covariance and gain
	localparam int DATA_W = 32;

	// gain is Q13, so unity gain is 8192
	localparam int GAIN_FRAC = 13;
	localparam int GAIN_ONE = 1 << GAIN_FRAC;

	// covariance seen on o_p out of reset
	localparam int P_INIT = 100000;

	// noise register values out of reset
	localparam int Q_RST = 5;
	localparam int R_RST = 10;

	// signed datapath word for x, p, errors and products
	typedef logic signed [DATA_W-1:0] data_t;

	// signed Q13 gain, also used for 8192 - k
	typedef logic signed [DATA_W-1:0] gain_t;

	// unsigned noise parameter for Q and R
	typedef logic [DATA_W-1:0] noise_t;

	// divider request, numerator is p << 13 and denominator is p + R
	typedef struct packed {
		data_t numer;
		data_t denom;
	} div_req_t;

endpackage

//--- files.f
common/kalman_pkg.sv
source/pipe_divider.sv
source/pipe_multiplier.sv
kalman_filter/kalman_core.sv
kalman_filter/kalman_filter_top.sv
verif/kalman_assert.sv
verif/kalman_tb.sv

//--- kalman_filter/kalman_core.sv
module kalman_core #(
	parameter int ADC_BIT = 14,
	parameter int DIV_LAT = 16,
	parameter int MUL_LAT = 2
) (
	input  logic                        i_clk,
	input  logic                        i_rst_n,
	input  logic signed [ADC_BIT-1:0]   i_meas,
	input  kalman_pkg::noise_t          i_kal_q,
	input  kalman_pkg::noise_t          i_kal_r,
	output kalman_pkg::div_req_t        o_div_req,
	input  kalman_pkg::gain_t           i_k,
	output kalman_pkg::gain_t           o_one_minus_k,
	output kalman_pkg::data_t           o_p_dly,
	output kalman_pkg::data_t           o_err,
	input  kalman_pkg::data_t           i_p_prod,
	input  kalman_pkg::data_t           i_fb_prod,
	output kalman_pkg::data_t           o_x,
	output kalman_pkg::data_t           o_p
);
	import kalman_pkg::*;

	// cycles from o_p back to o_p
	localparam int LOOP_LAT = DIV_LAT + MUL_LAT + 4;
	// state line, o_x back to the x update
	localparam int X_DLY = LOOP_LAT - 1;
	// predicted p line, up to the p multiplier input
	localparam int P_DLY = DIV_LAT + 3;
	localparam int CNT_W = $clog2(LOOP_LAT + 1);

	data_t meas_ext;
	noise_t q_r;
	noise_t r_r;
	data_t meas_pipe [0:DIV_LAT];
	data_t p_pre [0:P_DLY-1];
	data_t x_pre [0:X_DLY-1];
	div_req_t div_req_r;
	gain_t one_minus_k_r;
	data_t err_r;
	data_t fb_r;
	logic [CNT_W-1:0] init_cnt;

	// sign extension of the adc sample
	assign meas_ext = {{(DATA_W-ADC_BIT){i_meas[ADC_BIT-1]}}, i_meas};

	// input registers
	// the sample then rides alongside the divide so it meets its gain
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			q_r <= noise_t'(Q_RST);
			r_r <= noise_t'(R_RST);
			for (int i = 0; i <= DIV_LAT; i++) begin
				meas_pipe[i] <= '0;
			end
		end else begin
			q_r <= i_kal_q;
			r_r <= i_kal_r;
			meas_pipe[0] <= meas_ext;
			for (int i = 1; i <= DIV_LAT; i++) begin
				meas_pipe[i] <= meas_pipe[i-1];
			end
		end
	end

	// prediction, p + Q, and the delay lines for p and x
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < P_DLY; i++) begin
				p_pre[i] <= '0;
			end
			for (int i = 0; i < X_DLY; i++) begin
				x_pre[i] <= '0;
			end
		end else begin
			p_pre[0] <= o_p + data_t'(q_r);
			x_pre[0] <= o_x;
			for (int i = 1; i < P_DLY; i++) begin
				p_pre[i] <= p_pre[i-1];
			end
			for (int i = 1; i < X_DLY; i++) begin
				x_pre[i] <= x_pre[i-1];
			end
		end
	end

	// gain operands, p << 13 over p + R
	// 8192 - k once the quotient is back
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			div_req_r <= '0;
			one_minus_k_r <= '0;
		end else begin
			div_req_r.numer <= p_pre[0] <<< GAIN_FRAC;
			div_req_r.denom <= p_pre[0] + data_t'(r_r);
			one_minus_k_r <= gain_t'(GAIN_ONE) - i_k;
		end
	end

	// innovation is registered on the edge that k arrives
	// feedback keeps its sign through the Q13 shift
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			err_r <= '0;
			fb_r <= '0;
		end else begin
			err_r <= meas_pipe[DIV_LAT] - x_pre[DIV_LAT];
			fb_r <= i_fb_prod >>> GAIN_FRAC;
		end
	end

	// outputs hold their reset values until the loop has filled once
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			init_cnt <= CNT_W'(LOOP_LAT);
			o_p <= data_t'(P_INIT);
			o_x <= '0;
		end else if (init_cnt != '0) begin
			init_cnt <= init_cnt - 1'b1;
		end else begin
			o_p <= i_p_prod >> GAIN_FRAC;
			o_x <= x_pre[X_DLY-1] + fb_r;
		end
	end

	assign o_div_req = div_req_r;
	assign o_one_minus_k = one_minus_k_r;
	// predicted p lined up with 8192 - k at the multiplier
	assign o_p_dly = p_pre[P_DLY-1];
	assign o_err = err_r;

endmodule

//--- kalman_filter/kalman_filter_top.sv
module kalman_filter_top #(
	parameter int ADC_BIT = 14,
	parameter int DIV_LAT = 16,
	parameter int MUL_LAT = 2
) (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  logic signed [ADC_BIT-1:0] i_meas,
	input  kalman_pkg::noise_t        i_kal_q,
	input  kalman_pkg::noise_t        i_kal_r,
	output kalman_pkg::data_t         o_x,
	output kalman_pkg::data_t         o_p
);
	import kalman_pkg::*;

	div_req_t div_req;
	gain_t k;
	gain_t one_minus_k;
	data_t p_dly;
	data_t err;
	data_t p_prod;
	data_t fb_prod;

	// control, delay lines and the p and x updates
	kalman_core #(
		.ADC_BIT (ADC_BIT),
		.DIV_LAT (DIV_LAT),
		.MUL_LAT (MUL_LAT)
	) i_kalman_core (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_meas        (i_meas),
		.i_kal_q       (i_kal_q),
		.i_kal_r       (i_kal_r),
		.o_div_req     (div_req),
		.i_k           (k),
		.o_one_minus_k (one_minus_k),
		.o_p_dly       (p_dly),
		.o_err         (err),
		.i_p_prod      (p_prod),
		.i_fb_prod     (fb_prod),
		.o_x           (o_x),
		.o_p           (o_p)
	);

	// gain k
	pipe_divider #(
		.DIV_LAT (DIV_LAT)
	) i_pipe_divider (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_req   (div_req),
		.o_quot  (k)
	);

	// covariance update, (8192 - k) * p
	pipe_multiplier #(
		.MUL_LAT (MUL_LAT)
	) i_p_mult (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_a     (one_minus_k),
		.i_b     (p_dly),
		.o_prod  (p_prod)
	);

	// state feedback, k * err
	pipe_multiplier #(
		.MUL_LAT (MUL_LAT)
	) i_fb_mult (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_a     (k),
		.i_b     (err),
		.o_prod  (fb_prod)
	);

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the Kalman filter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module kalman_tb -o kalman_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/kalman_sim > sim.log 2>&1
cat sim.log

grep -q "Something failed" sim.log && { echo "simulation FAILED"; exit 1; } \
	|| { echo "simulation passed"; exit 0; }

//--- source/pipe_divider.sv
module pipe_divider #(
	parameter int DIV_LAT = 16
) (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  kalman_pkg::div_req_t i_req,
	output kalman_pkg::gain_t    o_quot
);
	import kalman_pkg::*;

	// quotient bits resolved in every stage
	localparam int STEPS = DATA_W / DIV_LAT;

	// one stage of the restoring divider
	// rem is one bit wider so the shifted-in bit never overflows
	typedef struct packed {
		logic [DATA_W:0]   rem;
		logic [DATA_W-1:0] num;
		logic [DATA_W-1:0] den;
		logic [DATA_W-1:0] quot;
	} div_stage_t;

	div_stage_t stage_in;
	div_stage_t stage_r [0:DIV_LAT-1];

	// STEPS restoring subtract steps, msb of the numerator first
	function automatic div_stage_t div_steps(input div_stage_t s_in);
		div_stage_t s;
		s = s_in;
		for (int i = 0; i < STEPS; i++) begin
			// bring down the next numerator bit
			s.rem = {s.rem[DATA_W-1:0], s.num[DATA_W-1]};
			s.num = {s.num[DATA_W-2:0], 1'b0};
			if (s.rem >= {1'b0, s.den}) begin
				s.rem  = s.rem - {1'b0, s.den};
				s.quot = {s.quot[DATA_W-2:0], 1'b1};
			end else begin
				// restore, the remainder is left as it was
				s.quot = {s.quot[DATA_W-2:0], 1'b0};
			end
		end
		return s;
	endfunction

	// first stage starts from an empty remainder and quotient
	// operands are taken as unsigned
	// a zero denominator drives every quotient bit to one
	always_comb begin
		stage_in.rem  = '0;
		stage_in.num  = i_req.numer;
		stage_in.den  = i_req.denom;
		stage_in.quot = '0;
	end

	// one division enters per cycle, no handshake
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int s = 0; s < DIV_LAT; s++) begin
				stage_r[s] <= '0;
			end
		end else begin
			stage_r[0] <= div_steps(stage_in);
			for (int s = 1; s < DIV_LAT; s++) begin
				stage_r[s] <= div_steps(stage_r[s-1]);
			end
		end
	end

	// quotient leaves DIV_LAT cycles after the request
	assign o_quot = stage_r[DIV_LAT-1].quot;

endmodule

//--- source/pipe_multiplier.sv
module pipe_multiplier #(
	parameter int MUL_LAT = 2
) (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  kalman_pkg::data_t i_a,
	input  kalman_pkg::data_t i_b,
	output kalman_pkg::data_t o_prod
);
	import kalman_pkg::*;

	data_t prod;
	data_t prod_r [0:MUL_LAT-1];

	// low word of the signed product
	assign prod = i_a * i_b;

	// output register chain, retimed into the multiply by synthesis
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int s = 0; s < MUL_LAT; s++) begin
				prod_r[s] <= '0;
			end
		end else begin
			prod_r[0] <= prod;
			for (int s = 1; s < MUL_LAT; s++) begin
				prod_r[s] <= prod_r[s-1];
			end
		end
	end

	assign o_prod = prod_r[MUL_LAT-1];

endmodule

//--- verif/kalman_assert.sv
module kalman_assert #(
	parameter int CNT_W = 5
) (
	input logic               i_clk,
	input logic               i_rst_n,
	input logic [CNT_W-1:0]   i_init_cnt,
	input kalman_pkg::noise_t i_q,
	input kalman_pkg::noise_t i_r,
	input kalman_pkg::data_t  i_x,
	input kalman_pkg::data_t  i_p
);
	import kalman_pkg::*;

	// outputs sit at their reset values while reset is low
	a_rst_out: assert property (@(posedge i_clk)
		!i_rst_n |-> (i_p == data_t'(P_INIT)) && (i_x == '0))
		else $error("outputs wrong during reset");

	// noise registers come out of reset at their defaults
	a_rst_noise: assert property (@(posedge i_clk)
		!i_rst_n |-> (i_q == noise_t'(Q_RST)) && (i_r == noise_t'(R_RST)))
		else $error("noise registers wrong during reset");

	// nothing moves on the outputs while the loop fills
	a_init_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_init_cnt != '0) |-> (i_p == data_t'(P_INIT)) && (i_x == '0))
		else $error("outputs moved during the init period");

endmodule

bind kalman_core kalman_assert #(.CNT_W(CNT_W)) i_kalman_assert (
	.i_clk      (i_clk),
	.i_rst_n    (i_rst_n),
	.i_init_cnt (init_cnt),
	.i_q        (q_r),
	.i_r        (r_r),
	.i_x        (o_x),
	.i_p        (o_p)
);

//--- verif/kalman_tb.sv
module kalman_tb;
	import kalman_pkg::*;

	localparam int ADC_BIT = 14;
	localparam int DIV_LAT = 16;
	localparam int MUL_LAT = 2;
	localparam int CLK_HALF = 20;
	localparam int RST_CYCLES = 4;
	localparam int ROWS = 50;
	// guards the trace reader against a runaway file
	localparam int MAX_LINES = 200;
	// watchdog limit in clock cycles, well above reset plus trace length
	localparam int MAX_CYCLES = 200;

	logic clk;
	logic rst_n;
	logic signed [ADC_BIT-1:0] meas;
	noise_t kal_q;
	noise_t kal_r;
	data_t x;
	data_t p;

	// one entry per trace row
	int tr_meas [0:ROWS-1];
	int tr_q [0:ROWS-1];
	int tr_r [0:ROWS-1];
	int tr_x [0:ROWS-1];
	int tr_p [0:ROWS-1];
	int n_rows;
	int err_cnt;
	int chk_cnt;
	logic trace_ok;

	kalman_filter_top #(
		.ADC_BIT (ADC_BIT),
		.DIV_LAT (DIV_LAT),
		.MUL_LAT (MUL_LAT)
	) i_kalman_filter_top (
		.i_clk   (clk),
		.i_rst_n (rst_n),
		.i_meas  (meas),
		.i_kal_q (kal_q),
		.i_kal_r (kal_r),
		.o_x     (x),
		.o_p     (p)
	);

	// 40 unit clock period
	initial clk = 1'b0;
	always #CLK_HALF clk = ~clk;

	// compare one output against its trace value
	task automatic compare(input string what, input longint act, input longint exp);
		if (act != exp) begin
			$display("error %0t: %s is %0d, expected %0d", $time, what, act, exp);
			err_cnt++;
		end
		chk_cnt++;
	endtask

	// load the trace, lines starting with # are comments
	task automatic read_trace(output logic ok);
		int fd;
		int code;
		int lines;
		int a;
		int b;
		int c;
		int d;
		int e;
		string line;
		ok = 1'b0;
		n_rows = 0;
		lines = 0;
		fd = $fopen("verif/kalman_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file verif/kalman_trace.txt");
		end else begin
			while (!$feof(fd) && n_rows < ROWS && lines < MAX_LINES) begin
				code = $fgets(line, fd);
				lines++;
				if (code > 0 && line.len() > 0 && line[0] != "#") begin
					if ($sscanf(line, "%d %d %d %d %d", a, b, c, d, e) == 5) begin
						tr_meas[n_rows] = a;
						tr_q[n_rows] = b;
						tr_r[n_rows] = c;
						tr_x[n_rows] = d;
						tr_p[n_rows] = e;
						n_rows++;
					end
				end
			end
			$fclose(fd);
			if (n_rows < ROWS) begin
				$display("the trace file ended after %0d of %0d rows", n_rows, ROWS);
			end else begin
				ok = 1'b1;
			end
		end
	endtask

	initial begin
		rst_n = 1'b1;
		meas = '0;
		kal_q = noise_t'(Q_RST);
		kal_r = noise_t'(R_RST);
		err_cnt = 0;
		chk_cnt = 0;
		read_trace(trace_ok);
		if (!trace_ok) begin
			$display("Something failed");
			$finish;
		end else begin
			// reset falls on the first falling edge and stays low for four cycles
			@(negedge clk);
			rst_n = 1'b0;
			repeat (RST_CYCLES) @(negedge clk);
			rst_n = 1'b1;
			// row t goes in before edge t+1, its outputs are read half a cycle later
			for (int t = 0; t < n_rows; t++) begin
				meas = tr_meas[t][ADC_BIT-1:0];
				kal_q = noise_t'(tr_q[t]);
				kal_r = noise_t'(tr_r[t]);
				@(negedge clk);
				compare($sformatf("o_x in row %0d", t + 1), x, tr_x[t]);
				compare($sformatf("o_p in row %0d", t + 1), p, tr_p[t]);
			end
			$display("checks %0d, errors %0d", chk_cnt, err_cnt);
			if (err_cnt == 0) begin
				$display("Everything OK");
			end else begin
				$display("Something failed");
			end
			$finish;
		end
	end

	// watchdog, ends a run that never reaches its end
	initial begin : watchdog
		int cyc;
		cyc = 0;
		while (cyc < MAX_CYCLES) begin
			@(posedge clk);
			cyc++;
		end
		$display("the simulation did not finish within %0d cycles", MAX_CYCLES);
		$display("Something failed");
		$finish;
	end

endmodule

//--- verif/kalman_trace.txt
# one row per clock edge after reset, decimal
# columns: sample, Q, R, expected o_x, expected o_p
1000 5 10 0 100000
1000 5 10 0 100000
1000 5 10 0 100000
1000 5 10 0 100000
1000 5 10 0 100000
1000 5 10 0 100000
1000 5 10 0 100000
1000 5 10 0 100000
1000 5 10 0 100000
1000 5 10 0 100000
-1500 5 10 0 100000
-1500 5 10 0 100000
-1500 5 10 0 100000
-1500 5 10 0 100000
-1500 5 10 0 100000
-1500 5 10 0 100000
1000 5 100000 0 100000
1000 5 100000 0 100000
1000 5 100000 0 100000
1000 50000 100000 0 100000
1000 50000 100000 0 100000
1000 50000 100000 0 100000
1000 50000 100000 999 12
1020 50000 100000 999 12
1040 50000 100000 999 12
1060 50000 100000 999 12
1080 50000 100000 999 12
1100 50000 100000 999 12
1120 50000 100000 999 12
1140 50000 100000 999 12
1160 50000 100000 999 12
1180 50000 100000 -1500 12
1200 50000 100000 -1500 12
1220 50000 100000 -1500 12
1240 50000 100000 -1500 12
1260 50000 100000 -1500 12
1280 50000 100000 -1500 12
1300 50000 100000 500 50002
1320 50000 100000 500 50002
1340 50000 100000 500 50002
1360 50000 100000 500 50002
1380 50000 100000 599 60003
1400 50000 100000 599 60003
1420 50000 100000 599 60003
1440 50000 100000 1006 33339
1460 50000 100000 1012 33339
1480 50000 100000 1019 33339
1500 50000 100000 1026 33339
1520 50000 100000 1032 33339
1540 50000 100000 1039 33339
